// File: hw/packetfilt_pkg.sv
`default_nettype none

package packetfilt_pkg;
	localparam int code_addr_width = 10;   // 1024 instructions
	localparam int packet_addr_width = 10; // 1024 words, 4 KiB
	localparam int code_word_width = 64;   // One instruction per word
	localparam int packet_word_width = 32; // Snooper and forwarder word size

	// Cut-down BPF opcode set, encodings borrowed from classic BPF
	typedef enum logic [7:0] {
		op_ld_abs     = 8'h20, // A <= pkt[k]
		op_and_k      = 8'h54, // A <= A & k
		op_jeq_k      = 8'h15, // pc += 1 + (A == k ? jt : jf)
		op_ret_accept = 8'h06,
		op_ret_drop   = 8'h16
	} op_e;

	// Field placement inside the 64-bit code word
	localparam int op_lsb = 56;
	localparam int op_width = 8;
	localparam int jt_lsb = 48;
	localparam int jt_width = 8;
	localparam int jf_lsb = 40;
	localparam int jf_width = 8;
	localparam int k_lsb = 0;
	localparam int k_width = 32;   // Bits 39..32 unused

	// Register byte offsets from BASEADDR
	localparam logic [31:0] reg_status = 32'h0;
	localparam logic [31:0] reg_control = 32'h4;
	localparam logic [31:0] reg_inst_low = 32'h8;
	localparam logic [31:0] reg_inst_high = 32'hc;

	typedef enum logic {
		verdict_drop   = 1'b0,
		verdict_accept = 1'b1
	} verdict_e;
endpackage

`default_nettype wire

// File: hw/word_ram.sv
`default_nettype none

module word_ram #(
	parameter type word_t = logic [31:0],
	parameter int depth_log2 = 10
) (
	input wire axi_aclk,
	input wire wr_en,
	input wire [depth_log2-1:0] wr_addr,
	input wire word_t wr_data,
	input wire rd_en,
	input wire [depth_log2-1:0] rd_addr,
	output word_t rd_data
);
	word_t mem [0:(1 << depth_log2)-1]; // Inferred block RAM

	always_ff @(posedge axi_aclk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		if (rd_en)
			rd_data <= mem[rd_addr]; // Data valid the cycle after rd_en
	end
endmodule

`default_nettype wire

// File: hw/packetfilt_regs.sv
`default_nettype none

module packetfilt_regs #(
	parameter int AXI_ADDR_WIDTH = 32,
	parameter logic [31:0] BASEADDR = 32'h0000_0000
) (
	input wire axi_aclk,
	input wire arst_n,
	input wire [AXI_ADDR_WIDTH-1:0] s_axi_awaddr,
	input wire [2:0] s_axi_awprot,
	input wire s_axi_awvalid,
	output logic s_axi_awready,
	input wire [31:0] s_axi_wdata,
	input wire [3:0] s_axi_wstrb,
	input wire s_axi_wvalid,
	output logic s_axi_wready,
	input wire [AXI_ADDR_WIDTH-1:0] s_axi_araddr,
	input wire [2:0] s_axi_arprot,
	input wire s_axi_arvalid,
	output logic s_axi_arready,
	output logic [31:0] s_axi_rdata,
	output logic [1:0] s_axi_rresp,
	output logic s_axi_rvalid,
	input wire s_axi_rready,
	output logic [1:0] s_axi_bresp,
	output logic s_axi_bvalid,
	input wire s_axi_bready,
	input wire drop_pulse,
	output logic control_start,
	output logic inst_low_strobe,
	output logic [31:0] inst_low_value,
	output logic inst_high_strobe,
	output logic [31:0] inst_high_value
);
	logic aw_held;                      // AW beat taken, waiting for W
	logic w_held;                       // W beat taken, waiting for AW
	logic [AXI_ADDR_WIDTH-1:0] aw_addr_q;
	logic [31:0] w_data_q;
	logic [3:0] w_strb_q;
	logic [15:0] num_packets_dropped;
	logic aw_hs;
	logic w_hs;
	logic ar_hs;
	logic wr_fire;                      // Both halves of a write present
	logic [AXI_ADDR_WIDTH-1:0] wr_off;
	logic [AXI_ADDR_WIDTH-1:0] rd_off;
	logic [31:0] wr_data;
	logic [3:0] wr_strb;

	// Word-aligned match of an offset against a register
	function automatic logic hit(input logic [AXI_ADDR_WIDTH-1:0] off,
			input logic [31:0] reg_off);
		return {off[AXI_ADDR_WIDTH-1:2], 2'b00} == AXI_ADDR_WIDTH'(reg_off);
	endfunction

	// Byte lane merge
	function automatic logic [31:0] apply_strb(input logic [31:0] old_val,
			input logic [31:0] new_val, input logic [3:0] strb);
		logic [31:0] res;
		res = old_val;
		for (int i = 0; i < 4; i++) begin
			if (strb[i])
				res[8*i +: 8] = new_val[8*i +: 8];
		end
		return res;
	endfunction

	assign aw_hs = s_axi_awvalid && s_axi_awready;
	assign w_hs = s_axi_wvalid && s_axi_wready;
	assign ar_hs = s_axi_arvalid && s_axi_arready;
	assign wr_fire = (aw_held || aw_hs) && (w_held || w_hs);
	assign wr_off = (aw_held ? aw_addr_q : s_axi_awaddr) - AXI_ADDR_WIDTH'(BASEADDR);
	assign wr_data = w_held ? w_data_q : s_axi_wdata;   // Held beat wins
	assign wr_strb = w_held ? w_strb_q : s_axi_wstrb;
	assign rd_off = s_axi_araddr - AXI_ADDR_WIDTH'(BASEADDR);
	assign s_axi_bresp = 2'b00;     // Always OKAY
	assign s_axi_rresp = 2'b00;

	always_ff @(posedge axi_aclk or negedge arst_n) begin
		if (!arst_n) begin
			s_axi_awready <= 1'b0;
			s_axi_wready <= 1'b0;
			s_axi_arready <= 1'b0;
			s_axi_bvalid <= 1'b0;
			s_axi_rvalid <= 1'b0;
			aw_held <= 1'b0;
			w_held <= 1'b0;
			control_start <= 1'b0;
			inst_low_strobe <= 1'b0;
			inst_high_strobe <= 1'b0;
			num_packets_dropped <= '0;
		end else begin
			// Ready pulses one cycle, never while a beat or response is pending
			s_axi_awready <= s_axi_awvalid && !s_axi_awready && !aw_held && !s_axi_bvalid;
			s_axi_wready <= s_axi_wvalid && !s_axi_wready && !w_held && !s_axi_bvalid;
			s_axi_arready <= s_axi_arvalid && !s_axi_arready && !s_axi_rvalid;
			if (wr_fire) begin
				aw_held <= 1'b0;
				w_held <= 1'b0;
				s_axi_bvalid <= 1'b1;
			end else begin
				if (aw_hs)
					aw_held <= 1'b1;
				if (w_hs)
					w_held <= 1'b1;
				if (s_axi_bready)
					s_axi_bvalid <= 1'b0;
			end
			inst_low_strobe <= wr_fire && hit(wr_off, packetfilt_pkg::reg_inst_low);
			inst_high_strobe <= wr_fire && hit(wr_off, packetfilt_pkg::reg_inst_high);
			if (wr_fire && hit(wr_off, packetfilt_pkg::reg_control) && wr_strb[0])
				control_start <= wr_data[0];
			if (drop_pulse && num_packets_dropped != 16'hffff)
				num_packets_dropped <= num_packets_dropped + 1'b1; // Saturates
			if (ar_hs)
				s_axi_rvalid <= 1'b1;
			else if (s_axi_rready)
				s_axi_rvalid <= 1'b0;
		end
	end

	always_ff @(posedge axi_aclk) begin
		if (aw_hs)
			aw_addr_q <= s_axi_awaddr;
		if (w_hs) begin
			w_data_q <= s_axi_wdata;
			w_strb_q <= s_axi_wstrb;
		end
		if (wr_fire && hit(wr_off, packetfilt_pkg::reg_inst_low))
			inst_low_value <= apply_strb(inst_low_value, wr_data, wr_strb);
		if (wr_fire && hit(wr_off, packetfilt_pkg::reg_inst_high))
			inst_high_value <= apply_strb(inst_high_value, wr_data, wr_strb);
		if (ar_hs) begin
			if (hit(rd_off, packetfilt_pkg::reg_status))
				s_axi_rdata <= {16'h0000, num_packets_dropped};
			else if (hit(rd_off, packetfilt_pkg::reg_control))
				s_axi_rdata <= {31'd0, control_start};
			else if (hit(rd_off, packetfilt_pkg::reg_inst_low))
				s_axi_rdata <= inst_low_value;
			else if (hit(rd_off, packetfilt_pkg::reg_inst_high))
				s_axi_rdata <= inst_high_value;
			else
				s_axi_rdata <= '0;  // Unmapped offsets read zero
		end
	end
endmodule

`default_nettype wire

// File: hw/code_store.sv
`default_nettype none

module code_store (
	input wire axi_aclk,
	input wire arst_n,
	input wire control_start,
	input wire inst_low_strobe,
	input wire [31:0] inst_low_value,
	input wire inst_high_strobe,
	input wire [31:0] inst_high_value,
	input wire code_rd_en,
	input wire [packetfilt_pkg::code_addr_width-1:0] code_rd_addr,
	output logic [packetfilt_pkg::code_word_width-1:0] code_rd_data
);
	logic have_low;     // Low half arrived since last commit
	logic have_high;
	logic start_q;      // For rising edge of start
	logic commit;
	logic [packetfilt_pkg::code_addr_width-1:0] wr_addr;

	// Pair is written only while the program is stopped
	assign commit = have_low && have_high && !control_start;

	always_ff @(posedge axi_aclk or negedge arst_n) begin
		if (!arst_n) begin
			have_low <= 1'b0;
			have_high <= 1'b0;
			start_q <= 1'b0;
			wr_addr <= '0;
		end else begin
			start_q <= control_start;
			if (control_start && !start_q)
				wr_addr <= '0;              // Next load starts over
			else if (commit)
				wr_addr <= wr_addr + 1'b1;
			if (commit) begin
				// A half landing in the commit cycle opens the next pair
				have_low <= inst_low_strobe;
				have_high <= inst_high_strobe;
			end else begin
				if (inst_low_strobe)
					have_low <= 1'b1;
				if (inst_high_strobe)
					have_high <= 1'b1;
			end
		end
	end

	word_ram #(
		.word_t(logic [packetfilt_pkg::code_word_width-1:0]),
		.depth_log2(packetfilt_pkg::code_addr_width)
	) u_code_ram (
		.axi_aclk(axi_aclk),
		.wr_en(commit),
		.wr_addr(wr_addr),
		.wr_data({inst_high_value, inst_low_value}),
		.rd_en(code_rd_en),
		.rd_addr(code_rd_addr),
		.rd_data(code_rd_data)
	);
endmodule

`default_nettype wire

// File: hw/packet_buffer.sv
`default_nettype none

module packet_buffer (
	input wire axi_aclk,
	input wire arst_n,
	input wire [packetfilt_pkg::packet_addr_width-1:0] snooper_wr_addr,
	input wire [packetfilt_pkg::packet_word_width-1:0] snooper_wr_data,
	input wire snooper_wr_en,
	input wire snooper_done,
	output logic ready_for_snooper,
	input wire pkt_rd_en,
	input wire [packetfilt_pkg::packet_addr_width-1:0] pkt_rd_addr,
	output logic [packetfilt_pkg::packet_word_width-1:0] pkt_rd_data,
	output logic pkt_ready,
	output logic [packetfilt_pkg::packet_addr_width:0] pkt_words,
	input wire accept_pulse,
	input wire drop_pulse,
	input wire [packetfilt_pkg::packet_addr_width-1:0] forwarder_rd_addr,
	input wire forwarder_rd_en,
	input wire forwarder_done,
	output logic [packetfilt_pkg::packet_word_width-1:0] forwarder_rd_data,
	output logic ready_for_forwarder,
	output logic [31:0] len_to_forwarder
);
	typedef enum logic [1:0] {
		st_fill,      // Snooper owns the buffer
		st_filter,    // Engine owns it
		st_forward    // Forwarder owns it
	} owner_e;

	owner_e owner;
	logic wr_en;
	logic [packetfilt_pkg::packet_addr_width:0] wr_words;   // Written address plus one
	logic rd_en;
	logic [packetfilt_pkg::packet_addr_width-1:0] rd_addr;
	logic [packetfilt_pkg::packet_word_width-1:0] rd_data;

	assign wr_en = snooper_wr_en && (owner == st_fill);   // Writes outside fill are ignored
	assign wr_words = {1'b0, snooper_wr_addr} + 1'b1;
	// Single read port, granted by owner
	assign rd_en = (owner == st_filter) ? pkt_rd_en : (owner == st_forward) && forwarder_rd_en;
	assign rd_addr = (owner == st_forward) ? forwarder_rd_addr : pkt_rd_addr;
	assign pkt_rd_data = rd_data;
	assign forwarder_rd_data = rd_data;
	assign ready_for_snooper = owner == st_fill;
	assign pkt_ready = owner == st_filter;
	assign ready_for_forwarder = owner == st_forward;
	assign len_to_forwarder = 32'({pkt_words, 2'b00});   // Bytes

	always_ff @(posedge axi_aclk or negedge arst_n) begin
		if (!arst_n) begin
			owner <= st_fill;
			pkt_words <= '0;
		end else begin
			case (owner)
				st_fill: begin
					if (wr_en && wr_words > pkt_words)
						pkt_words <= wr_words;     // Track highest address
					if (snooper_done)
						owner <= st_filter;
				end
				st_filter: begin
					if (accept_pulse) begin
						owner <= st_forward;
					end else if (drop_pulse) begin
						owner <= st_fill;          // Freed at once
						pkt_words <= '0;
					end
				end
				st_forward: begin
					if (forwarder_done) begin
						owner <= st_fill;
						pkt_words <= '0;
					end
				end
				default: owner <= st_fill;
			endcase
		end
	end

	word_ram #(
		.word_t(logic [packetfilt_pkg::packet_word_width-1:0]),
		.depth_log2(packetfilt_pkg::packet_addr_width)
	) u_pkt_ram (
		.axi_aclk(axi_aclk),
		.wr_en(wr_en),
		.wr_addr(snooper_wr_addr),
		.wr_data(snooper_wr_data),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);
endmodule

`default_nettype wire

// File: hw/filter_engine.sv
`default_nettype none

module filter_engine (
	input wire axi_aclk,
	input wire arst_n,
	input wire control_start,
	input wire pkt_ready,
	input wire [packetfilt_pkg::packet_addr_width:0] pkt_words,
	input wire [packetfilt_pkg::code_word_width-1:0] code_rd_data,
	input wire [packetfilt_pkg::packet_word_width-1:0] pkt_rd_data,
	output logic code_rd_en,
	output logic [packetfilt_pkg::code_addr_width-1:0] code_rd_addr,
	output logic pkt_rd_en,
	output logic [packetfilt_pkg::packet_addr_width-1:0] pkt_rd_addr,
	output logic accept_pulse,
	output logic drop_pulse
);
	localparam int pc_width = packetfilt_pkg::code_addr_width + 1;  // Extra bit flags overrun

	typedef enum logic [2:0] {
		st_idle,
		st_fetch,    // Code read issued
		st_exec,     // Instruction on code_rd_data
		st_load,     // Packet word on pkt_rd_data
		st_done      // Verdict given, wait for buffer to move on
	} state_e;

	state_e state;
	state_e state_nxt;
	logic [pc_width-1:0] pc;
	logic [pc_width-1:0] pc_nxt;
	logic [pc_width-1:0] jump_off;
	logic [31:0] acc;             // BPF A register
	packetfilt_pkg::op_e op;
	logic [31:0] k;
	logic finish;
	packetfilt_pkg::verdict_e verdict;

	assign op = packetfilt_pkg::op_e'(code_rd_data[packetfilt_pkg::op_lsb +: packetfilt_pkg::op_width]);
	assign k = code_rd_data[packetfilt_pkg::k_lsb +: packetfilt_pkg::k_width];
	assign jump_off = (acc == k) ?
		pc_width'(code_rd_data[packetfilt_pkg::jt_lsb +: packetfilt_pkg::jt_width]) :
		pc_width'(code_rd_data[packetfilt_pkg::jf_lsb +: packetfilt_pkg::jf_width]);
	assign code_rd_addr = pc[pc_width-2:0];
	assign pkt_rd_addr = k[packetfilt_pkg::packet_addr_width-1:0];

	always_comb begin
		state_nxt = state;
		pc_nxt = pc;
		code_rd_en = 1'b0;
		pkt_rd_en = 1'b0;
		finish = 1'b0;
		verdict = packetfilt_pkg::verdict_drop;  // Anything odd drops
		case (state)
			st_idle: begin
				if (control_start && pkt_ready) begin
					state_nxt = st_fetch;
					pc_nxt = '0;
				end
			end
			st_fetch: begin
				if (pc[pc_width-1]) begin
					finish = 1'b1;               // Ran off the end of code memory
				end else begin
					code_rd_en = 1'b1;
					state_nxt = st_exec;
				end
			end
			st_exec: begin
				case (op)
					packetfilt_pkg::op_ld_abs: begin
						if (k >= 32'(pkt_words)) begin
							finish = 1'b1;       // Beyond packet
						end else begin
							pkt_rd_en = 1'b1;
							state_nxt = st_load;
						end
					end
					packetfilt_pkg::op_and_k: begin
						pc_nxt = pc + 1'b1;
						state_nxt = st_fetch;
					end
					packetfilt_pkg::op_jeq_k: begin
						pc_nxt = pc + jump_off + 1'b1;
						state_nxt = st_fetch;
					end
					packetfilt_pkg::op_ret_accept: begin
						finish = 1'b1;
						verdict = packetfilt_pkg::verdict_accept;
					end
					default: finish = 1'b1;      // ret_drop and unknown opcodes
				endcase
			end
			st_load: begin
				pc_nxt = pc + 1'b1;
				state_nxt = st_fetch;
			end
			st_done: begin
				if (!pkt_ready)
					state_nxt = st_idle;
			end
			default: state_nxt = st_idle;
		endcase
		if (finish)
			state_nxt = st_done;
		// Start cleared mid-run, back to pc 0 with packet kept
		if (!control_start && (state inside {st_fetch, st_exec, st_load})) begin
			state_nxt = st_idle;
			pc_nxt = '0;
			finish = 1'b0;
			code_rd_en = 1'b0;
			pkt_rd_en = 1'b0;
		end
	end

	always_ff @(posedge axi_aclk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
			pc <= '0;
			acc <= '0;
			accept_pulse <= 1'b0;
			drop_pulse <= 1'b0;
		end else begin
			state <= state_nxt;
			pc <= pc_nxt;
			accept_pulse <= finish && verdict == packetfilt_pkg::verdict_accept;
			drop_pulse <= finish && verdict == packetfilt_pkg::verdict_drop;
			if (state == st_idle)
				acc <= '0;
			else if (state == st_exec && op == packetfilt_pkg::op_and_k)
				acc <= acc & k;
			else if (state == st_load)
				acc <= pkt_rd_data;
		end
	end
endmodule

`default_nettype wire

// File: hw/packetfilt.sv
`default_nettype none

module packetfilt #(
	parameter int AXI_ADDR_WIDTH = 32,
	parameter logic [31:0] BASEADDR = 32'h0000_0000
) (
	input wire axi_aclk,
	input wire arst_n,
	input wire [AXI_ADDR_WIDTH-1:0] s_axi_awaddr,
	input wire [2:0] s_axi_awprot,
	input wire s_axi_awvalid,
	output logic s_axi_awready,
	input wire [31:0] s_axi_wdata,
	input wire [3:0] s_axi_wstrb,
	input wire s_axi_wvalid,
	output logic s_axi_wready,
	input wire [AXI_ADDR_WIDTH-1:0] s_axi_araddr,
	input wire [2:0] s_axi_arprot,
	input wire s_axi_arvalid,
	output logic s_axi_arready,
	output logic [31:0] s_axi_rdata,
	output logic [1:0] s_axi_rresp,
	output logic s_axi_rvalid,
	input wire s_axi_rready,
	output logic [1:0] s_axi_bresp,
	output logic s_axi_bvalid,
	input wire s_axi_bready,
	input wire [packetfilt_pkg::packet_addr_width-1:0] snooper_wr_addr,
	input wire [packetfilt_pkg::packet_word_width-1:0] snooper_wr_data,
	input wire snooper_wr_en,
	input wire snooper_done,           // One-cycle pulse
	output logic ready_for_snooper,
	input wire [packetfilt_pkg::packet_addr_width-1:0] forwarder_rd_addr,
	input wire forwarder_rd_en,
	input wire forwarder_done,         // One-cycle pulse
	output logic [packetfilt_pkg::packet_word_width-1:0] forwarder_rd_data,
	output logic ready_for_forwarder,
	output logic [31:0] len_to_forwarder
);
	// Register file to code store
	logic control_start;
	logic inst_low_strobe;
	logic [31:0] inst_low_value;
	logic inst_high_strobe;
	logic [31:0] inst_high_value;
	// Engine to code store and buffer
	logic code_rd_en;
	logic [packetfilt_pkg::code_addr_width-1:0] code_rd_addr;
	logic [packetfilt_pkg::code_word_width-1:0] code_rd_data;
	logic pkt_rd_en;
	logic [packetfilt_pkg::packet_addr_width-1:0] pkt_rd_addr;
	logic [packetfilt_pkg::packet_word_width-1:0] pkt_rd_data;
	logic pkt_ready;
	logic [packetfilt_pkg::packet_addr_width:0] pkt_words;
	logic accept_pulse;
	logic drop_pulse;     // Also feeds the Status counter

	packetfilt_regs #(
		.AXI_ADDR_WIDTH(AXI_ADDR_WIDTH),
		.BASEADDR(BASEADDR)
	) u_regs (.*);

	code_store u_code_store (.*);

	packet_buffer u_packet_buffer (.*);

	filter_engine u_filter_engine (.*);
endmodule

`default_nettype wire

// File: tests/packetfilt_sva.sv
`default_nettype none

module packetfilt_sva (
	input wire axi_aclk,
	input wire arst_n,
	input wire accept_pulse,
	input wire drop_pulse,
	input wire ready_for_snooper,
	input wire ready_for_forwarder,
	input wire snooper_done
);
	int fail_count = 0;   // Failed assertions so far

	// One verdict per packet and never both
	verdict_onehot: assert property (@(posedge axi_aclk) disable iff (!arst_n)
		!(accept_pulse && drop_pulse))
		else begin
			fail_count++;
			$error("accept_pulse and drop_pulse high in the same cycle");
		end

	// Buffer has a single owner
	owner_exclusive: assert property (@(posedge axi_aclk) disable iff (!arst_n)
		!(ready_for_snooper && ready_for_forwarder))
		else begin
			fail_count++;
			$error("ready_for_snooper and ready_for_forwarder high together");
		end

	done_single: assert property (@(posedge axi_aclk) disable iff (!arst_n)
		snooper_done |=> !snooper_done)
		else begin
			fail_count++;
			$error("snooper_done held for more than one cycle");
		end
endmodule

bind packet_buffer packetfilt_sva u_sva (.*);

`default_nettype wire

// File: tests/packetfilt_tb.sv
`default_nettype none

module packetfilt_tb;
	localparam int num_packets = 49;
	localparam int cycle_limit = 200 * num_packets + 2000;
	localparam logic [31:0] magic = 32'h0800_4500;   // Header word the filters look for

	logic axi_aclk = 1'b0;
	logic arst_n;
	logic [31:0] s_axi_awaddr;
	logic [2:0] s_axi_awprot;
	logic s_axi_awvalid;
	logic s_axi_awready;
	logic [31:0] s_axi_wdata;
	logic [3:0] s_axi_wstrb;
	logic s_axi_wvalid;
	logic s_axi_wready;
	logic [31:0] s_axi_araddr;
	logic [2:0] s_axi_arprot;
	logic s_axi_arvalid;
	logic s_axi_arready;
	logic [31:0] s_axi_rdata;
	logic [1:0] s_axi_rresp;
	logic s_axi_rvalid;
	logic s_axi_rready;
	logic [1:0] s_axi_bresp;
	logic s_axi_bvalid;
	logic s_axi_bready;
	logic [9:0] snooper_wr_addr;
	logic [31:0] snooper_wr_data;
	logic snooper_wr_en;
	logic snooper_done;
	logic ready_for_snooper;
	logic [9:0] forwarder_rd_addr;
	logic forwarder_rd_en;
	logic forwarder_done;
	logic [31:0] forwarder_rd_data;
	logic ready_for_forwarder;
	logic [31:0] len_to_forwarder;

	logic [63:0] prog [0:1023];   // Mirror of code memory
	logic [31:0] pkt [0:1023];    // Packet being sent
	logic exp_q [$];              // Expected verdicts with 1 for accept
	logic exp_v;
	logic rff_q;
	logic rfs_q;
	logic fwd_rd_q;               // Forwarder read issued last cycle
	logic [9:0] fwd_addr_q;
	integer seed = 32'hc4d0_e8ba;
	int errors = 0;
	int verdicts_checked = 0;
	int words_checked = 0;
	int exp_drops = 0;
	int cycles = 0;

	packetfilt DUT (.*);

	always #4 axi_aclk = ~axi_aclk;

	// Watchdog
	always @(posedge axi_aclk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			$display("Test failed");
			$finish;
		end
	end

	function automatic logic [63:0] make_inst(input logic [7:0] op, input logic [7:0] jt,
			input logic [7:0] jf, input logic [31:0] k);
		return {op, jt, jf, 8'h00, k};
	endfunction

	// Interprets prog over pkt and returns 1 for accept
	function automatic logic ref_verdict(input int n_words);
		int pc;
		logic [31:0] acc;
		logic [63:0] inst;
		logic [31:0] k;
		pc = 0;
		acc = '0;
		for (int step = 0; step < 4096; step++) begin
			if (pc >= 1024)
				return 1'b0;              // Off the end of code memory
			inst = prog[pc];
			k = inst[31:0];
			case (inst[63:56])
				packetfilt_pkg::op_ld_abs: begin
					if (k >= n_words)
						return 1'b0;
					acc = pkt[k];
					pc++;
				end
				packetfilt_pkg::op_and_k: begin
					acc = acc & k;
					pc++;
				end
				packetfilt_pkg::op_jeq_k: pc = pc + 1 + ((acc == k) ? inst[55:48] : inst[47:40]);
				packetfilt_pkg::op_ret_accept: return 1'b1;
				default: return 1'b0;          // ret_drop and unknown opcodes
			endcase
		end
		return 1'b0;
	endfunction

	task automatic axi_write(input logic [31:0] addr, input logic [31:0] data);
		logic aw_done;
		logic w_done;
		aw_done = 1'b0;
		w_done = 1'b0;
		@(posedge axi_aclk);
		s_axi_awaddr <= addr;
		s_axi_awvalid <= 1'b1;
		s_axi_wdata <= data;
		s_axi_wstrb <= 4'hf;
		s_axi_wvalid <= 1'b1;
		while (!(aw_done && w_done)) begin
			@(posedge axi_aclk);
			if (!aw_done && s_axi_awready) begin
				aw_done = 1'b1;
				s_axi_awvalid <= 1'b0;
			end
			if (!w_done && s_axi_wready) begin
				w_done = 1'b1;
				s_axi_wvalid <= 1'b0;
			end
		end
		do @(posedge axi_aclk); while (!s_axi_bvalid);   // bready held high
		assert (s_axi_bresp == 2'b00)
			else begin
				errors++;
				$display("[FAIL] %0t: bresp %0d on write to 0x%08h", $time, s_axi_bresp, addr);
			end
	endtask

	task automatic axi_read(input logic [31:0] addr, output logic [31:0] data);
		@(posedge axi_aclk);
		s_axi_araddr <= addr;
		s_axi_arvalid <= 1'b1;
		do @(posedge axi_aclk); while (!s_axi_arready);
		s_axi_arvalid <= 1'b0;
		do @(posedge axi_aclk); while (!s_axi_rvalid);
		data = s_axi_rdata;
		assert (s_axi_rresp == 2'b00)
			else begin
				errors++;
				$display("[FAIL] %0t: rresp %0d on read of 0x%08h", $time, s_axi_rresp, addr);
			end
	endtask

	// Stop, load n instructions from prog, start again
	task automatic load_program(input int n, input logic mixed);
		axi_write(packetfilt_pkg::reg_control, 32'd0);
		for (int i = 0; i < n; i++) begin
			if (mixed && i % 2 == 1) begin
				axi_write(packetfilt_pkg::reg_inst_high, prog[i][63:32]);   // High half first
				axi_write(packetfilt_pkg::reg_inst_low, prog[i][31:0]);
			end else begin
				axi_write(packetfilt_pkg::reg_inst_low, prog[i][31:0]);
				axi_write(packetfilt_pkg::reg_inst_high, prog[i][63:32]);
			end
		end
		axi_write(packetfilt_pkg::reg_control, 32'd1);
	endtask

	task automatic fill_random(input int n);
		for (int i = 0; i < n; i++)
			pkt[i] = $random(seed);
	endtask

	task automatic forward_packet(input int n);
		assert (len_to_forwarder == 32'(4 * n))
			else begin
				errors++;
				$display("[FAIL] %0t: len_to_forwarder %0d, expected %0d", $time,
					len_to_forwarder, 4 * n);
			end
		for (int i = 0; i < n; i++) begin
			forwarder_rd_en <= 1'b1;
			forwarder_rd_addr <= 10'(i);
			@(posedge axi_aclk);
			forwarder_rd_en <= 1'b0;
			@(posedge axi_aclk);              // Word on forwarder_rd_data here
		end
		forwarder_done <= 1'b1;
		@(posedge axi_aclk);
		forwarder_done <= 1'b0;
	endtask

	// Write n words, signal done, wait for the verdict
	task automatic send_packet(input int n);
		logic v;
		v = ref_verdict(n);
		exp_q.push_back(v);
		if (!v)
			exp_drops++;
		@(posedge axi_aclk);
		while (!ready_for_snooper)
			@(posedge axi_aclk);
		for (int i = 0; i < n; i++) begin
			snooper_wr_en <= 1'b1;
			snooper_wr_addr <= 10'(i);
			snooper_wr_data <= pkt[i];
			@(posedge axi_aclk);
		end
		snooper_wr_en <= 1'b0;
		snooper_done <= 1'b1;
		@(posedge axi_aclk);
		snooper_done <= 1'b0;
		do @(posedge axi_aclk); while (!(ready_for_forwarder || ready_for_snooper));
		if (ready_for_forwarder)
			forward_packet(n);
	endtask

	// Forwarder grant is an accept and a buffer freed without it is a drop
	always @(posedge axi_aclk) begin
		if (!arst_n) begin
			rff_q <= 1'b0;
			rfs_q <= 1'b1;
			fwd_rd_q <= 1'b0;
			fwd_addr_q <= '0;
		end else begin
			rff_q <= ready_for_forwarder;
			rfs_q <= ready_for_snooper;
			fwd_rd_q <= forwarder_rd_en;
			fwd_addr_q <= forwarder_rd_addr;
			if (fwd_rd_q) begin
				words_checked++;
				assert (forwarder_rd_data == pkt[fwd_addr_q])
					else begin
						errors++;
						$display("[FAIL] %0t: word %0d read 0x%08h, expected 0x%08h", $time,
							fwd_addr_q, forwarder_rd_data, pkt[fwd_addr_q]);
					end
			end
			if ((ready_for_forwarder && !rff_q) || (ready_for_snooper && !rfs_q && !rff_q)) begin
				assert (exp_q.size() != 0)
					else begin
						errors++;
						$display("Unexpected verdict at time %0t with no packet outstanding", $time);
					end
				if (exp_q.size() != 0) begin
					exp_v = exp_q.pop_front();
					verdicts_checked++;
					assert (ready_for_forwarder == exp_v)
						else begin
							errors++;
							$display("[FAIL] %0t: verdict %s, expected %s", $time,
								ready_for_forwarder ? "accept" : "drop", exp_v ? "accept" : "drop");
						end
				end
			end
		end
	end

	initial begin
		logic [31:0] rd;
		int n;
		int sva_fails;
		arst_n <= 1'b0;
		s_axi_awaddr <= '0;
		s_axi_awprot <= '0;
		s_axi_awvalid <= 1'b0;
		s_axi_wdata <= '0;
		s_axi_wstrb <= '0;
		s_axi_wvalid <= 1'b0;
		s_axi_araddr <= '0;
		s_axi_arprot <= '0;
		s_axi_arvalid <= 1'b0;
		s_axi_rready <= 1'b1;
		s_axi_bready <= 1'b1;
		snooper_wr_addr <= '0;
		snooper_wr_data <= '0;
		snooper_wr_en <= 1'b0;
		snooper_done <= 1'b0;
		forwarder_rd_addr <= '0;
		forwarder_rd_en <= 1'b0;
		forwarder_done <= 1'b0;
		repeat (10) @(posedge axi_aclk);
		arst_n <= 1'b1;
		@(posedge axi_aclk);

		// Reset state
		assert (ready_for_snooper === 1'b1 && ready_for_forwarder === 1'b0)
			else begin
				errors++;
				$display("[FAIL] %0t: after reset ready_for_snooper %b ready_for_forwarder %b",
					$time, ready_for_snooper, ready_for_forwarder);
			end
		axi_read(packetfilt_pkg::reg_status, rd);
		assert (rd == 32'd0)
			else begin
				errors++;
				$display("[FAIL] %0t: Status 0x%08h after reset", $time, rd);
			end

		// Header match with halves in mixed order
		prog[0] = make_inst(packetfilt_pkg::op_ld_abs, 8'd0, 8'd0, 32'd0);
		prog[1] = make_inst(packetfilt_pkg::op_jeq_k, 8'd0, 8'd1, magic);
		prog[2] = make_inst(packetfilt_pkg::op_ret_accept, 8'd0, 8'd0, 32'd0);
		prog[3] = make_inst(packetfilt_pkg::op_ret_drop, 8'd0, 8'd0, 32'd0);
		load_program(4, 1'b1);
		repeat (3) begin
			fill_random(8);
			pkt[0] = magic;
			send_packet(8);
		end

		// Non-matching headers
		repeat (3) begin
			fill_random(6);
			pkt[0] = magic ^ ({$random(seed)} | 32'h1);
			send_packet(6);
		end
		axi_read(packetfilt_pkg::reg_status, rd);
		assert (rd[15:0] == 16'(exp_drops))
			else begin
				errors++;
				$display("[FAIL] %0t: drop count %0d, expected %0d", $time, rd[15:0], exp_drops);
			end

		// Mask and jump chain whose second load reaches past short packets
		prog[0] = make_inst(packetfilt_pkg::op_ld_abs, 8'd0, 8'd0, 32'd1);
		prog[1] = make_inst(packetfilt_pkg::op_and_k, 8'd0, 8'd0, 32'h3);
		prog[2] = make_inst(packetfilt_pkg::op_jeq_k, 8'd3, 8'd0, 32'd0);   // 0 to accept
		prog[3] = make_inst(packetfilt_pkg::op_jeq_k, 8'd3, 8'd0, 32'd1);   // 1 to second test
		prog[4] = make_inst(packetfilt_pkg::op_jeq_k, 8'd1, 8'd0, 32'd2);   // 2 to accept
		prog[5] = make_inst(packetfilt_pkg::op_ret_drop, 8'd0, 8'd0, 32'd0);
		prog[6] = make_inst(packetfilt_pkg::op_ret_accept, 8'd0, 8'd0, 32'd0);
		prog[7] = make_inst(packetfilt_pkg::op_ld_abs, 8'd0, 8'd0, 32'd6);
		prog[8] = make_inst(packetfilt_pkg::op_and_k, 8'd0, 8'd0, 32'h1);
		prog[9] = make_inst(packetfilt_pkg::op_jeq_k, 8'd0, 8'd1, 32'd1);
		prog[10] = make_inst(packetfilt_pkg::op_ret_accept, 8'd0, 8'd0, 32'd0);
		prog[11] = make_inst(packetfilt_pkg::op_ret_drop, 8'd0, 8'd0, 32'd0);
		load_program(12, 1'b0);
		repeat (40) begin
			n = 4 + int'({$random(seed)} % 7);
			fill_random(n);
			send_packet(n);
		end

		// Word 6 of a 5-word packet
		fill_random(5);
		pkt[1] = 32'h0000_0005;
		send_packet(5);

		// Reload from address 0 with the sense inverted
		prog[0] = make_inst(packetfilt_pkg::op_ld_abs, 8'd0, 8'd0, 32'd0);
		prog[1] = make_inst(packetfilt_pkg::op_jeq_k, 8'd1, 8'd0, magic);
		prog[2] = make_inst(packetfilt_pkg::op_ret_accept, 8'd0, 8'd0, 32'd0);
		prog[3] = make_inst(packetfilt_pkg::op_ret_drop, 8'd0, 8'd0, 32'd0);
		load_program(4, 1'b1);
		fill_random(4);
		pkt[0] = magic;
		send_packet(4);
		fill_random(4);
		pkt[0] = ~magic;
		send_packet(4);

		axi_read(packetfilt_pkg::reg_status, rd);
		assert (rd[15:0] == 16'(exp_drops))
			else begin
				errors++;
				$display("[FAIL] %0t: drop count %0d, expected %0d", $time, rd[15:0], exp_drops);
			end
		repeat (2) @(posedge axi_aclk);
		assert (exp_q.size() == 0)
			else begin
				errors++;
				$display("%0d packets ended without a verdict", exp_q.size());
			end

		sva_fails = DUT.u_packet_buffer.u_sva.fail_count;
		$display("Errors: %0d check, %0d assertion; %0d verdicts and %0d words checked",
			errors, sva_fails, verdicts_checked, words_checked);
		if (errors == 0 && sva_fails == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end
endmodule

`default_nettype wire

// File: filelist.f
hw/packetfilt_pkg.sv
hw/word_ram.sv
hw/packetfilt_regs.sv
hw/code_store.sv
hw/packet_buffer.sv
hw/filter_engine.sv
hw/packetfilt.sv
tests/packetfilt_sva.sv
tests/packetfilt_tb.sv
